// ==== rtl/sha256_pkg.sv ====
`default_nettype none

package sha256_pkg;

	typedef logic [31:0] sha256_word_t;
	typedef logic [5:0]  sha256_round_t;

	// Word 0 sits in the top bits, first word of the message
	typedef sha256_word_t [0:15] sha256_block_t;

	// Field order matches the digest order, a is the top word
	typedef struct packed {
		sha256_word_t a;
		sha256_word_t b;
		sha256_word_t c;
		sha256_word_t d;
		sha256_word_t e;
		sha256_word_t f;
		sha256_word_t g;
		sha256_word_t h;
	} sha256_state_t;

	typedef struct packed {
		logic          load;
		logic          round_en;
		logic          finalize;
		sha256_round_t round;
	} sha256_ctl_t;

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_ROUNDS,
		SEQ_FINAL
	} seq_state_e;

	////////////////////////////////////////////////////////////
	// Constants from FIPS 180-4
	////////////////////////////////////////////////////////////

	localparam sha256_state_t SHA256_IV = '{
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

	localparam sha256_word_t SHA256_K [0:63] = '{
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
		32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
		32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
		32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
		32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
		32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
		32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
		32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
		32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
		32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
		32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	////////////////////////////////////////////////////////////
	// Word functions
	////////////////////////////////////////////////////////////

	function automatic sha256_word_t rotr(input sha256_word_t x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	function automatic sha256_word_t big_sigma0(input sha256_word_t x);
		return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
	endfunction

	function automatic sha256_word_t big_sigma1(input sha256_word_t x);
		return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
	endfunction

	function automatic sha256_word_t small_sigma0(input sha256_word_t x);
		return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
	endfunction

	function automatic sha256_word_t small_sigma1(input sha256_word_t x);
		return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
	endfunction

	// Bitwise select between f and g under e
	function automatic sha256_word_t choose(
		input sha256_word_t x,
		input sha256_word_t y,
		input sha256_word_t z
	);
		return (x & y) ^ (~x & z);
	endfunction

	function automatic sha256_word_t majority(
		input sha256_word_t x,
		input sha256_word_t y,
		input sha256_word_t z
	);
		return (x & y) ^ (x & z) ^ (y & z);
	endfunction

endpackage

`default_nettype wire

// ==== rtl/sha256_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module sha256_control (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   start,
	output sha256_pkg::sha256_ctl_t ctl,
	output logic                   busy,
	output logic                   digest_valid
);

	import sha256_pkg::*;

	seq_state_e    state_q;
	seq_state_e    state_d;
	sha256_round_t cnt_q;
	logic          valid_q;

	////////////////////////////////////////////////////////////
	// Next state and strobes
	////////////////////////////////////////////////////////////

	always_comb
	begin
		ctl = '0;
		ctl.round = cnt_q;
		state_d = state_q;
		case (state_q)
			SEQ_IDLE:
			begin
				// Load fires on the same edge that samples start
				if (start)
				begin
					ctl.load = 1'b1;
					state_d = SEQ_ROUNDS;
				end
			end
			SEQ_ROUNDS:
			begin
				ctl.round_en = 1'b1;
				if (cnt_q == 6'd63)
				begin
					state_d = SEQ_FINAL;
				end
			end
			SEQ_FINAL:
			begin
				ctl.finalize = 1'b1;
				state_d = SEQ_IDLE;
			end
			default:
			begin
				state_d = SEQ_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state_q <= SEQ_IDLE;
			cnt_q <= '0;
			valid_q <= 1'b0;
		end
		else
		begin
			state_q <= state_d;
			valid_q <= ctl.finalize;
			// Counter wraps back to 0 after round 63
			if (ctl.load)
			begin
				cnt_q <= '0;
			end
			else if (ctl.round_en)
			begin
				cnt_q <= cnt_q + 6'd1;
			end
		end
	end

	assign busy = (state_q != SEQ_IDLE);
	assign digest_valid = valid_q;

	a_valid_single: assert property (@(posedge clk) disable iff (rst)
		digest_valid |=> !digest_valid);

endmodule

`default_nettype wire

// ==== rtl/sha256_msg_schedule.sv ====
`timescale 1ns/1ps
`default_nettype none

module sha256_msg_schedule (
	input  logic                      clk,
	input  logic                      rst,
	input  sha256_pkg::sha256_ctl_t   ctl,
	input  sha256_pkg::sha256_block_t block,
	output sha256_pkg::sha256_word_t  w
);

	import sha256_pkg::*;

	// win_q[k] holds W[r+k] while round r runs
	sha256_block_t win_q;
	sha256_word_t  w_next;
	sha256_word_t  s0;
	sha256_word_t  s1;

	////////////////////////////////////////////////////////////
	// Expansion
	////////////////////////////////////////////////////////////

	// W[r+16] from W[r+14], W[r+9], W[r+1] and W[r]
	assign s1 = small_sigma1(win_q[14]);
	assign s0 = small_sigma0(win_q[1]);
	assign w_next = s1 + win_q[9] + s0 + win_q[0];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			win_q <= '0;
		end
		else if (ctl.load)
		begin
			win_q <= block;
		end
		else if (ctl.round_en)
		begin
			// Drop the oldest word, append the expanded one
			win_q <= {win_q[1:15], w_next};
		end
	end

	// Oldest word feeds the current round
	assign w = win_q[0];

endmodule

`default_nettype wire

// ==== rtl/sha256_round_logic.sv ====
`timescale 1ns/1ps
`default_nettype none

module sha256_round_logic (
	input  sha256_pkg::sha256_state_t state,
	input  sha256_pkg::sha256_word_t  w,
	input  sha256_pkg::sha256_round_t round,
	output sha256_pkg::sha256_word_t  t1,
	output sha256_pkg::sha256_word_t  t2
);

	import sha256_pkg::*;

	sha256_word_t sum1;
	sha256_word_t ch;
	sha256_word_t sum0;
	sha256_word_t maj;
	sha256_word_t k;

	////////////////////////////////////////////////////////////
	// Round function terms
	////////////////////////////////////////////////////////////

	// Constant for this round
	assign k = SHA256_K[round];

	// e side
	assign sum1 = big_sigma1(state.e);
	assign ch = choose(state.e, state.f, state.g);

	// a side
	assign sum0 = big_sigma0(state.a);
	assign maj = majority(state.a, state.b, state.c);

	assign t1 = state.h + sum1 + ch + k + w;
	assign t2 = sum0 + maj;

endmodule

`default_nettype wire

// ==== rtl/sha256_state_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module sha256_state_regs (
	input  logic                      clk,
	input  logic                      rst,
	input  sha256_pkg::sha256_ctl_t   ctl,
	input  sha256_pkg::sha256_word_t  t1,
	input  sha256_pkg::sha256_word_t  t2,
	output sha256_pkg::sha256_state_t state,
	output sha256_pkg::sha256_state_t digest
);

	import sha256_pkg::*;

	sha256_state_t work_q;
	sha256_state_t digest_q;
	logic          loaded_q;

	////////////////////////////////////////////////////////////
	// Working variables a to h
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (ctl.load)
		begin
			work_q <= SHA256_IV;
		end
		else if (ctl.round_en)
		begin
			work_q.h <= work_q.g;
			work_q.g <= work_q.f;
			work_q.f <= work_q.e;
			work_q.e <= work_q.d + t1;
			work_q.d <= work_q.c;
			work_q.c <= work_q.b;
			work_q.b <= work_q.a;
			work_q.a <= t1 + t2;
		end
	end

	// Feed-forward of the initial values into the digest
	always_ff @(posedge clk)
	begin
		if (ctl.finalize)
		begin
			digest_q.a <= work_q.a + SHA256_IV.a;
			digest_q.b <= work_q.b + SHA256_IV.b;
			digest_q.c <= work_q.c + SHA256_IV.c;
			digest_q.d <= work_q.d + SHA256_IV.d;
			digest_q.e <= work_q.e + SHA256_IV.e;
			digest_q.f <= work_q.f + SHA256_IV.f;
			digest_q.g <= work_q.g + SHA256_IV.g;
			digest_q.h <= work_q.h + SHA256_IV.h;
		end
	end

	// Set once a block has been taken since reset
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			loaded_q <= 1'b0;
		end
		else if (ctl.load)
		begin
			loaded_q <= 1'b1;
		end
	end

	assign state = work_q;
	assign digest = digest_q;

	a_ctl_exclusive: assert property (@(posedge clk) disable iff (rst)
		$onehot0({ctl.load, ctl.round_en, ctl.finalize}));

	a_round_after_load: assert property (@(posedge clk) disable iff (rst)
		ctl.round_en |-> loaded_q);

endmodule

`default_nettype wire

// ==== rtl/sha256_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module sha256_core (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      start,
	input  sha256_pkg::sha256_block_t block,
	output logic                      busy,
	output logic                      digest_valid,
	output sha256_pkg::sha256_state_t digest
);

	import sha256_pkg::*;

	sha256_ctl_t   ctl;
	sha256_word_t  w;
	sha256_word_t  t1;
	sha256_word_t  t2;
	sha256_state_t state;

	////////////////////////////////////////////////////////////
	// Sequencer
	////////////////////////////////////////////////////////////

	sha256_control i_control (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.ctl          (ctl),
		.busy         (busy),
		.digest_valid (digest_valid)
	);

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	sha256_msg_schedule i_msg_schedule (
		.clk   (clk),
		.rst   (rst),
		.ctl   (ctl),
		.block (block),
		.w     (w)
	);

	sha256_round_logic i_round_logic (
		.state (state),
		.w     (w),
		.round (ctl.round),
		.t1    (t1),
		.t2    (t2)
	);

	sha256_state_regs i_state_regs (
		.clk    (clk),
		.rst    (rst),
		.ctl    (ctl),
		.t1     (t1),
		.t2     (t2),
		.state  (state),
		.digest (digest)
	);

endmodule

`default_nettype wire

// ==== testbench/tb_sha256_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_sha256_core;

	import sha256_pkg::*;

	localparam int TIMEOUT = 200;
	localparam int LATENCY = 65;

	// Published digest of "abc"
	localparam sha256_state_t ABC_DIGEST = {
		32'hba7816bf, 32'h8f01cfea, 32'h414140de, 32'h5dae2223,
		32'hb00361a3, 32'h96177a9c, 32'hb410ff61, 32'hf20015ad
	};

	logic          clk;
	logic          rst;
	logic          start;
	sha256_block_t block;
	logic          busy;
	logic          digest_valid;
	sha256_state_t digest;

	sha256_state_t exp_q[$];
	int            err_count;
	int            pass_count;
	int            fail_count;
	int            seed;

	sha256_core i_dut (
		.clk          (clk),
		.rst          (rst),
		.start        (start),
		.block        (block),
		.busy         (busy),
		.digest_valid (digest_valid),
		.digest       (digest)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	function automatic sha256_state_t ref_compress(input sha256_block_t blk);
		sha256_word_t  sched [0:63];
		sha256_word_t  a, b, c, d, e, f, g, h;
		sha256_word_t  t1, t2;
		sha256_state_t res;
		for (int i = 0; i < 16; i++)
			sched[i] = blk[i];
		for (int i = 16; i < 64; i++)
			sched[i] = small_sigma1(sched[i-2]) + sched[i-7] + small_sigma0(sched[i-15])
				+ sched[i-16];
		a = SHA256_IV.a;
		b = SHA256_IV.b;
		c = SHA256_IV.c;
		d = SHA256_IV.d;
		e = SHA256_IV.e;
		f = SHA256_IV.f;
		g = SHA256_IV.g;
		h = SHA256_IV.h;
		for (int i = 0; i < 64; i++)
		begin
			t1 = h + big_sigma1(e) + choose(e, f, g) + SHA256_K[i] + sched[i];
			t2 = big_sigma0(a) + majority(a, b, c);
			h = g;
			g = f;
			f = e;
			e = d + t1;
			d = c;
			c = b;
			b = a;
			a = t1 + t2;
		end
		res = {a + SHA256_IV.a, b + SHA256_IV.b, c + SHA256_IV.c, d + SHA256_IV.d,
			e + SHA256_IV.e, f + SHA256_IV.f, g + SHA256_IV.g, h + SHA256_IV.h};
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////

	task automatic mismatch(input string sig, input string got, input string expv);
		$display("[FAIL] %0t ns %s: got %s expected %s", $time, sig, got, expv);
		err_count++;
	endtask

	// Advance to 1 ns after the next n rising edges
	task automatic step(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic make_random_block(output sha256_block_t blk);
		for (int i = 0; i < 16; i++)
			blk[i] = $random(seed);
	endtask

	// Queues the expected digest, returns just after the sampling edge
	task automatic issue_start(input sha256_block_t blk);
		exp_q.push_back(ref_compress(blk));
		start = 1'b1;
		block = blk;
		step(1);
		start = 1'b0;
	endtask

	task automatic wait_digest(output int edges);
		bit busy_bad;
		edges = 0;
		busy_bad = 0;
		while (digest_valid !== 1'b1 && edges < TIMEOUT)
		begin
			if (busy !== 1'b1 && !busy_bad)
			begin
				mismatch("busy", $sformatf("%b", busy), "1");
				busy_bad = 1;
			end
			step(1);
			edges++;
		end
		if (digest_valid !== 1'b1)
		begin
			$display("%0t ns: digest_valid did not rise within %0d cycles", $time, TIMEOUT);
			err_count++;
		end
		else if (busy !== 1'b0)
			mismatch("busy", $sformatf("%b", busy), "0");
	endtask

	// One block, with latency and pulse width checked
	task automatic run_one(input sha256_block_t blk);
		int edges;
		issue_start(blk);
		wait_digest(edges);
		if (edges != LATENCY)
			mismatch("start to digest_valid edges", $sformatf("%0d", edges), "65");
		step(1);
		if (digest_valid !== 1'b0)
			mismatch("digest_valid", $sformatf("%b", digest_valid), "0");
	endtask

	task automatic finish_test(input string name, input int errs_at_start);
		step(1);
		if (exp_q.size() != 0)
		begin
			$display("%0t ns: %0d expected digests never arrived", $time, exp_q.size());
			err_count++;
			exp_q.delete();
		end
		if (err_count == errs_at_start)
		begin
			$display("test %s: passed", name);
			pass_count++;
		end
		else
		begin
			$display("test %s: failed with %0d errors", name, err_count - errs_at_start);
			fail_count++;
		end
	endtask

	////////////////////////////////////////////////////////////
	// Comparison process
	////////////////////////////////////////////////////////////

	initial
	begin : compare_proc
		int            waited;
		sha256_state_t exp_digest;
		waited = 0;
		forever
		begin
			@(negedge clk);
			if (digest_valid === 1'b1)
			begin
				if (exp_q.size() == 0)
				begin
					$display("%0t ns: digest_valid without an accepted start", $time);
					err_count++;
				end
				else
				begin
					exp_digest = exp_q.pop_front();
					if (digest !== exp_digest)
						mismatch("digest", $sformatf("%h", digest),
							$sformatf("%h", exp_digest));
				end
				waited = 0;
			end
			else if (exp_q.size() != 0)
			begin
				waited++;
				// Drop the overdue entry so later blocks still line up
				if (waited > TIMEOUT)
				begin
					$display("%0t ns: no digest within %0d cycles", $time, TIMEOUT);
					err_count++;
					void'(exp_q.pop_front());
					waited = 0;
				end
			end
			else
				waited = 0;
		end
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial
	begin
		sha256_block_t blk;
		sha256_block_t other;
		sha256_block_t chain [0:3];
		int            errs;
		int            edges;
		int            pulses;
		seed = 32'h6441_43d1;
		err_count = 0;
		pass_count = 0;
		fail_count = 0;
		rst = 1'b1;
		start = 1'b0;
		block = '0;
		repeat (2) @(posedge clk);
		#1;
		rst = 1'b0;

		// Padded "abc"
		errs = err_count;
		blk = '0;
		blk[0] = 32'h61626380;
		blk[15] = 32'h00000018;
		if (ref_compress(blk) !== ABC_DIGEST)
			mismatch("ref_compress abc", $sformatf("%h", ref_compress(blk)),
				$sformatf("%h", ABC_DIGEST));
		run_one(blk);
		finish_test("abc block with timing", errs);

		errs = err_count;
		blk = '0;
		blk[0] = 32'h80000000;
		run_one(blk);
		finish_test("empty message", errs);

		errs = err_count;
		repeat (20)
		begin
			make_random_block(blk);
			run_one(blk);
		end
		finish_test("twenty random blocks", errs);

		// Second start mid computation must be dropped
		errs = err_count;
		make_random_block(blk);
		make_random_block(other);
		issue_start(blk);
		step(10);
		start = 1'b1;
		block = other;
		step(1);
		start = 1'b0;
		wait_digest(edges);
		pulses = 0;
		for (int i = 0; i < 80; i++)
		begin
			step(1);
			if (digest_valid === 1'b1)
				pulses++;
		end
		if (pulses != 0)
			mismatch("extra digest_valid pulses", $sformatf("%0d", pulses), "0");
		finish_test("start while busy", errs);

		errs = err_count;
		for (int i = 0; i < 4; i++)
			make_random_block(chain[i]);
		issue_start(chain[0]);
		for (int i = 1; i < 4; i++)
		begin
			wait_digest(edges);
			if (edges != LATENCY)
				mismatch("start to digest_valid edges", $sformatf("%0d", edges), "65");
			issue_start(chain[i]);
			if (digest_valid !== 1'b0)
				mismatch("digest_valid", $sformatf("%b", digest_valid), "0");
		end
		wait_digest(edges);
		finish_test("back to back starts", errs);

		errs = err_count;
		make_random_block(blk);
		issue_start(blk);
		step(20);
		rst = 1'b1;
		exp_q.delete();
		step(2);
		rst = 1'b0;
		if (busy !== 1'b0)
			mismatch("busy", $sformatf("%b", busy), "0");
		pulses = 0;
		for (int i = 0; i < 100; i++)
		begin
			step(1);
			if (digest_valid === 1'b1)
				pulses++;
		end
		if (pulses != 0)
			mismatch("digest_valid pulses after reset", $sformatf("%0d", pulses), "0");
		make_random_block(blk);
		run_one(blk);
		finish_test("reset mid computation", errs);

		$display("tests passed: %0d, tests failed: %0d, errors: %0d",
			pass_count, fail_count, err_count);
		if (fail_count == 0 && err_count == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/sha256_pkg.sv
rtl/sha256_control.sv
rtl/sha256_msg_schedule.sv
rtl/sha256_round_logic.sv
rtl/sha256_state_regs.sv
rtl/sha256_core.sv
testbench/tb_sha256_core.sv

// ==== Bender.yml ====
package:
  name: sha256_core

sources:
  - rtl/sha256_pkg.sv
  - rtl/sha256_control.sv
  - rtl/sha256_msg_schedule.sv
  - rtl/sha256_round_logic.sv
  - rtl/sha256_state_regs.sv
  - rtl/sha256_core.sv
  - target: simulation
    files:
      - testbench/tb_sha256_core.sv
